// ==== logic/ctrlPkg.sv ====
package ctrlPkg;

    typedef logic [5:0] opcode_t;
    typedef logic [5:0] funct_t;

    typedef struct packed {
        opcode_t opcode;
        funct_t  funct;
    } instrFields_t;

    // comparison flags from the ALU
    typedef struct packed {
        logic gt;
        logic lt;
        logic et;
    } aluFlags_t;

    typedef logic [2:0] memAddrSel_t;
    typedef logic [1:0] aluSrcASel_t;
    typedef logic [2:0] aluSrcBSel_t;
    typedef logic [1:0] pcSrcSel_t;
    typedef logic [1:0] regDstSel_t;
    typedef logic [2:0] regDataSel_t;
    typedef logic [2:0] aluOp_t;

    typedef struct packed {
        logic        writePc;
        logic        writeA;
        logic        writeB;
        logic        writeAluOut;
        logic        writeInstr;
        logic        writeReg;
        logic        writeHilo;
        logic        hiloSel;    // 0 mult result, 1 div result
        logic        divStart;
        logic        multStart;
        memAddrSel_t memAddrSel;
        aluSrcASel_t aluSrcA;
        aluSrcBSel_t aluSrcB;
        pcSrcSel_t   pcSrc;
        regDstSel_t  regDst;
        regDataSel_t regData;
        aluOp_t      aluOp;
    } ctrlWord_t;

    typedef enum logic [3:0] {
        opNone, opAdd, opAnd, opSub,
        opAddi, opAddiu, opMult, opDiv,
        opMfhi, opMflo, opBeq, opBne,
        opBle, opBgt, opBreak, opRte
    } opKind_t;

    typedef enum logic [2:0] {
        fpFetch0, fpFetch1, fpFetch2, fpFetchPc,
        fpPrecalc, fpDecode, fpWait
    } fetchPhase_t;

    // 17 phases, so 5 bits
    typedef enum logic [4:0] {
        epIdle, epAluOp, epImmOp, epSaveReg, epSaveImm,
        epMultGo, epMultWait, epMultDone,
        epDivGo, epDivWait, epDivDone,
        epMoveHilo, epCmp, epResolve,
        epBreakCalc, epBreakPc, epRte
    } execPhase_t;

    // opcodes
    localparam opcode_t OP_RTYPE = 6'b000000;
    localparam opcode_t OP_ADDI  = 6'b001000;
    localparam opcode_t OP_ADDIU = 6'b001001;
    localparam opcode_t OP_BEQ   = 6'b000100;
    localparam opcode_t OP_BNE   = 6'b000101;
    localparam opcode_t OP_BLE   = 6'b000110;
    localparam opcode_t OP_BGT   = 6'b000111;

    // funct codes, register type only
    localparam funct_t FUNCT_ADD   = 6'b100000;
    localparam funct_t FUNCT_AND   = 6'b100100;
    localparam funct_t FUNCT_SUB   = 6'b100010;
    localparam funct_t FUNCT_MULT  = 6'b011000;
    localparam funct_t FUNCT_DIV   = 6'b011010;
    localparam funct_t FUNCT_MFHI  = 6'b010000;
    localparam funct_t FUNCT_MFLO  = 6'b010010;
    localparam funct_t FUNCT_BREAK = 6'b001101;
    localparam funct_t FUNCT_RTE   = 6'b010011;

    localparam memAddrSel_t MEM_PC = 3'b010;

    localparam aluSrcASel_t SRCA_REG = 2'b01;

    localparam aluSrcBSel_t SRCB_REG    = 3'b000;
    localparam aluSrcBSel_t SRCB_FOUR   = 3'b001;
    localparam aluSrcBSel_t SRCB_OFFSET = 3'b010;
    localparam aluSrcBSel_t SRCB_IMM    = 3'b011;

    localparam pcSrcSel_t PC_EPC    = 2'b01;
    localparam pcSrcSel_t PC_ALUOUT = 2'b10;

    localparam regDstSel_t DST_RD = 2'b00;
    localparam regDstSel_t DST_SP = 2'b01;  // stack register
    localparam regDstSel_t DST_RT = 2'b11;

    localparam regDataSel_t DATA_ALUOUT = 3'b000;
    localparam regDataSel_t DATA_LO     = 3'b001;
    localparam regDataSel_t DATA_HI     = 3'b010;
    localparam regDataSel_t DATA_SP     = 3'b011;  // initial stack value

    localparam aluOp_t ALU_ADD = 3'b001;
    localparam aluOp_t ALU_SUB = 3'b010;
    localparam aluOp_t ALU_AND = 3'b011;
    localparam aluOp_t ALU_CMP = 3'b111;

    // reset loads the stack register
    localparam ctrlWord_t RESET_WORD = '{
        writeReg: 1'b1,
        regDst:   DST_SP,
        regData:  DATA_SP,
        default:  '0
    };

    localparam ctrlWord_t IDLE_WORD = '0;

endpackage

// ==== logic/fetchDecodeSeq.sv ====
`timescale 1ns/1ps

module fetchDecodeSeq (
    input  logic                  clk,
    input  logic                  reset,
    input  ctrlPkg::instrFields_t instr,
    input  logic                  opDone,
    output logic                  opStart,
    output ctrlPkg::opKind_t      opKind,
    output logic                  fetchBusy,
    output ctrlPkg::ctrlWord_t    fetchWord
);

    ctrlPkg::fetchPhase_t phase;
    ctrlPkg::fetchPhase_t phaseNext;
    ctrlPkg::opKind_t     decoded;

    // decode table
    always_comb begin
        decoded = ctrlPkg::opNone;
        case (instr.opcode)
            ctrlPkg::OP_RTYPE: begin
                case (instr.funct)
                    ctrlPkg::FUNCT_ADD:   decoded = ctrlPkg::opAdd;
                    ctrlPkg::FUNCT_AND:   decoded = ctrlPkg::opAnd;
                    ctrlPkg::FUNCT_SUB:   decoded = ctrlPkg::opSub;
                    ctrlPkg::FUNCT_MULT:  decoded = ctrlPkg::opMult;
                    ctrlPkg::FUNCT_DIV:   decoded = ctrlPkg::opDiv;
                    ctrlPkg::FUNCT_MFHI:  decoded = ctrlPkg::opMfhi;
                    ctrlPkg::FUNCT_MFLO:  decoded = ctrlPkg::opMflo;
                    ctrlPkg::FUNCT_BREAK: decoded = ctrlPkg::opBreak;
                    ctrlPkg::FUNCT_RTE:   decoded = ctrlPkg::opRte;
                    default:              decoded = ctrlPkg::opNone;
                endcase
            end
            ctrlPkg::OP_ADDI:  decoded = ctrlPkg::opAddi;
            ctrlPkg::OP_ADDIU: decoded = ctrlPkg::opAddiu;
            ctrlPkg::OP_BEQ:   decoded = ctrlPkg::opBeq;
            ctrlPkg::OP_BNE:   decoded = ctrlPkg::opBne;
            ctrlPkg::OP_BLE:   decoded = ctrlPkg::opBle;
            ctrlPkg::OP_BGT:   decoded = ctrlPkg::opBgt;
            default:           decoded = ctrlPkg::opNone;
        endcase
    end

    assign opKind    = decoded;
    assign opStart   = (phase == ctrlPkg::fpDecode) && (decoded != ctrlPkg::opNone);
    assign fetchBusy = (phase != ctrlPkg::fpWait);

    always_comb begin
        case (phase)
            ctrlPkg::fpFetch0:  phaseNext = ctrlPkg::fpFetch1;
            ctrlPkg::fpFetch1:  phaseNext = ctrlPkg::fpFetch2;
            ctrlPkg::fpFetch2:  phaseNext = ctrlPkg::fpFetchPc;
            ctrlPkg::fpFetchPc: phaseNext = ctrlPkg::fpPrecalc;
            ctrlPkg::fpPrecalc: phaseNext = ctrlPkg::fpDecode;
            ctrlPkg::fpDecode: begin
                // unknown instruction goes straight back to fetch
                if (decoded == ctrlPkg::opNone) begin
                    phaseNext = ctrlPkg::fpFetch0;
                end else begin
                    phaseNext = ctrlPkg::fpWait;
                end
            end
            ctrlPkg::fpWait: begin
                if (opDone) begin
                    phaseNext = ctrlPkg::fpFetch0;
                end else begin
                    phaseNext = ctrlPkg::fpWait;
                end
            end
            default: phaseNext = ctrlPkg::fpFetch0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            phase <= ctrlPkg::fpFetch0;
        end else begin
            phase <= phaseNext;
        end
    end

    always_comb begin
        fetchWord = ctrlPkg::IDLE_WORD;
        case (phase)
            ctrlPkg::fpFetch0, ctrlPkg::fpFetch1, ctrlPkg::fpFetch2: begin
                fetchWord.writeInstr  = 1'b1;
                fetchWord.writeAluOut = 1'b1;   // pc + 4
                fetchWord.memAddrSel  = ctrlPkg::MEM_PC;
                fetchWord.aluSrcB     = ctrlPkg::SRCB_FOUR;
                fetchWord.aluOp       = ctrlPkg::ALU_ADD;
            end
            ctrlPkg::fpFetchPc: begin
                fetchWord.writePc = 1'b1;
                fetchWord.pcSrc   = ctrlPkg::PC_ALUOUT;
            end
            ctrlPkg::fpPrecalc, ctrlPkg::fpDecode: begin
                // branch target precalc, operands loaded on decode
                fetchWord.writeAluOut = (phase == ctrlPkg::fpPrecalc);
                fetchWord.writeA      = (phase == ctrlPkg::fpDecode);
                fetchWord.writeB      = (phase == ctrlPkg::fpDecode);
                fetchWord.memAddrSel  = ctrlPkg::MEM_PC;
                fetchWord.aluSrcB     = ctrlPkg::SRCB_OFFSET;
                fetchWord.aluOp       = ctrlPkg::ALU_ADD;
                fetchWord.pcSrc       = ctrlPkg::PC_ALUOUT;
            end
            default: fetchWord = ctrlPkg::IDLE_WORD;
        endcase
    end

endmodule

// ==== logic/executeSeq.sv ====
`timescale 1ns/1ps

module executeSeq (
    input  logic               clk,
    input  logic               reset,
    input  logic               opStart,
    input  ctrlPkg::opKind_t   opKind,
    input  ctrlPkg::aluFlags_t flags,
    input  logic               multEnd,
    input  logic               divEnd,
    output logic               opDone,
    output ctrlPkg::ctrlWord_t execWord
);

    ctrlPkg::execPhase_t phase;
    ctrlPkg::execPhase_t phaseNext;
    ctrlPkg::execPhase_t startPhase;
    ctrlPkg::opKind_t    kind;
    logic                taken;

    // entry phase per instruction
    always_comb begin
        case (opKind)
            ctrlPkg::opAdd, ctrlPkg::opAnd, ctrlPkg::opSub: startPhase = ctrlPkg::epAluOp;
            ctrlPkg::opAddi, ctrlPkg::opAddiu:              startPhase = ctrlPkg::epImmOp;
            ctrlPkg::opMult:                                startPhase = ctrlPkg::epMultGo;
            ctrlPkg::opDiv:                                 startPhase = ctrlPkg::epDivGo;
            ctrlPkg::opMfhi, ctrlPkg::opMflo:               startPhase = ctrlPkg::epMoveHilo;
            ctrlPkg::opBeq, ctrlPkg::opBne,
            ctrlPkg::opBle, ctrlPkg::opBgt:                 startPhase = ctrlPkg::epCmp;
            ctrlPkg::opBreak:                               startPhase = ctrlPkg::epBreakCalc;
            ctrlPkg::opRte:                                 startPhase = ctrlPkg::epRte;
            default:                                        startPhase = ctrlPkg::epIdle;
        endcase
    end

    always_comb begin
        case (kind)
            ctrlPkg::opBeq: taken = flags.et;
            ctrlPkg::opBne: taken = !flags.et;
            ctrlPkg::opBle: taken = flags.et || flags.lt;
            ctrlPkg::opBgt: taken = flags.gt;
            default:        taken = 1'b0;
        endcase
    end

    always_comb begin
        case (phase)
            ctrlPkg::epIdle: begin
                if (opStart) begin
                    phaseNext = startPhase;
                end else begin
                    phaseNext = ctrlPkg::epIdle;
                end
            end
            ctrlPkg::epAluOp:     phaseNext = ctrlPkg::epSaveReg;
            ctrlPkg::epImmOp:     phaseNext = ctrlPkg::epSaveImm;
            ctrlPkg::epMultGo:    phaseNext = ctrlPkg::epMultWait;
            ctrlPkg::epMultWait: begin
                if (multEnd) begin
                    phaseNext = ctrlPkg::epMultDone;
                end else begin
                    phaseNext = ctrlPkg::epMultWait;
                end
            end
            ctrlPkg::epDivGo:     phaseNext = ctrlPkg::epDivWait;
            ctrlPkg::epDivWait: begin
                if (divEnd) begin
                    phaseNext = ctrlPkg::epDivDone;
                end else begin
                    phaseNext = ctrlPkg::epDivWait;
                end
            end
            ctrlPkg::epCmp:       phaseNext = ctrlPkg::epResolve;
            ctrlPkg::epBreakCalc: phaseNext = ctrlPkg::epBreakPc;
            default:              phaseNext = ctrlPkg::epIdle;  // final phases
        endcase
    end

    always_comb begin
        case (phase)
            ctrlPkg::epSaveReg, ctrlPkg::epSaveImm,
            ctrlPkg::epMultDone, ctrlPkg::epDivDone,
            ctrlPkg::epMoveHilo, ctrlPkg::epResolve,
            ctrlPkg::epBreakPc, ctrlPkg::epRte: opDone = 1'b1;
            default:                            opDone = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            phase <= ctrlPkg::epIdle;
        end else begin
            phase <= phaseNext;
        end
    end

    always_ff @(posedge clk) begin
        if (opStart) begin
            kind <= opKind;
        end
    end

    always_comb begin
        execWord = ctrlPkg::IDLE_WORD;
        case (phase)
            ctrlPkg::epAluOp, ctrlPkg::epImmOp: begin
                execWord.writeAluOut = 1'b1;
                execWord.memAddrSel  = ctrlPkg::MEM_PC;
                execWord.pcSrc       = ctrlPkg::PC_ALUOUT;
                execWord.aluSrcA     = ctrlPkg::SRCA_REG;
                if (phase == ctrlPkg::epImmOp) begin
                    execWord.aluSrcB = ctrlPkg::SRCB_IMM;
                    execWord.aluOp   = ctrlPkg::ALU_ADD;
                end else begin
                    execWord.aluSrcB = ctrlPkg::SRCB_REG;
                    case (kind)
                        ctrlPkg::opAnd: execWord.aluOp = ctrlPkg::ALU_AND;
                        ctrlPkg::opSub: execWord.aluOp = ctrlPkg::ALU_SUB;
                        default:        execWord.aluOp = ctrlPkg::ALU_ADD;
                    endcase
                end
            end
            ctrlPkg::epSaveReg, ctrlPkg::epSaveImm: begin
                execWord.writeReg   = 1'b1;
                execWord.memAddrSel = ctrlPkg::MEM_PC;
                execWord.pcSrc      = ctrlPkg::PC_ALUOUT;
                execWord.aluSrcA    = ctrlPkg::SRCA_REG;
                execWord.aluOp      = ctrlPkg::ALU_ADD;
                execWord.regData    = ctrlPkg::DATA_ALUOUT;
                // immediate forms write rt
                execWord.regDst = (phase == ctrlPkg::epSaveImm) ? ctrlPkg::DST_RT
                                                                : ctrlPkg::DST_RD;
            end
            ctrlPkg::epMultGo: execWord.multStart = 1'b1;
            ctrlPkg::epDivGo:  execWord.divStart  = 1'b1;
            ctrlPkg::epMultDone, ctrlPkg::epDivDone: begin
                execWord.writeHilo = 1'b1;
                execWord.hiloSel   = (phase == ctrlPkg::epDivDone);
            end
            ctrlPkg::epMoveHilo: begin
                execWord.writeReg = 1'b1;
                execWord.regDst   = ctrlPkg::DST_RD;
                execWord.regData  = (kind == ctrlPkg::opMfhi) ? ctrlPkg::DATA_HI
                                                              : ctrlPkg::DATA_LO;
            end
            ctrlPkg::epCmp: begin
                execWord.aluSrcA = ctrlPkg::SRCA_REG;
                execWord.aluOp   = ctrlPkg::ALU_CMP;
            end
            ctrlPkg::epResolve: begin
                if (taken) begin   // target already in aluOut from precalc
                    execWord.writePc     = 1'b1;
                    execWord.writeAluOut = 1'b1;
                    execWord.pcSrc       = ctrlPkg::PC_ALUOUT;
                end
            end
            ctrlPkg::epBreakCalc: begin
                execWord.writeAluOut = 1'b1;   // pc - 4
                execWord.aluSrcB     = ctrlPkg::SRCB_FOUR;
                execWord.aluOp       = ctrlPkg::ALU_SUB;
            end
            ctrlPkg::epBreakPc: begin
                execWord.writePc = 1'b1;
                execWord.pcSrc   = ctrlPkg::PC_ALUOUT;
            end
            ctrlPkg::epRte: begin
                execWord.writePc = 1'b1;
                execWord.pcSrc   = ctrlPkg::PC_EPC;
            end
            default: execWord = ctrlPkg::IDLE_WORD;
        endcase
    end

endmodule

// ==== logic/ctrlWordMerge.sv ====
`timescale 1ns/1ps

module ctrlWordMerge (
    input  logic               clk,
    input  logic               reset,
    input  logic               fetchBusy,
    input  ctrlPkg::ctrlWord_t fetchWord,
    input  ctrlPkg::ctrlWord_t execWord,
    output ctrlPkg::ctrlWord_t ctrl
);

    ctrlPkg::ctrlWord_t activeWord;

    // only one sequencer is active at a time
    assign activeWord = fetchBusy ? fetchWord : execWord;

    always_ff @(posedge clk) begin
        if (reset) begin
            ctrl <= ctrlPkg::RESET_WORD;
        end else begin
            ctrl <= activeWord;
        end
    end

endmodule

// ==== logic/ctrlUnit.sv ====
`timescale 1ns/1ps

module ctrlUnit (
    input  logic                  clk,
    input  logic                  reset,
    input  ctrlPkg::instrFields_t instr,
    input  ctrlPkg::aluFlags_t    flags,
    input  logic                  multEnd,
    input  logic                  divEnd,
    output ctrlPkg::ctrlWord_t    ctrl
);

    logic               opStart;
    logic               opDone;
    logic               fetchBusy;
    ctrlPkg::opKind_t   opKind;
    ctrlPkg::ctrlWord_t fetchWord;
    ctrlPkg::ctrlWord_t execWord;

    fetchDecodeSeq i_fetchSeq (
        .clk       (clk),
        .reset     (reset),
        .instr     (instr),
        .opDone    (opDone),
        .opStart   (opStart),
        .opKind    (opKind),
        .fetchBusy (fetchBusy),
        .fetchWord (fetchWord)
    );

    executeSeq i_execSeq (
        .clk      (clk),
        .reset    (reset),
        .opStart  (opStart),
        .opKind   (opKind),
        .flags    (flags),
        .multEnd  (multEnd),
        .divEnd   (divEnd),
        .opDone   (opDone),
        .execWord (execWord)
    );

    // registered output stage
    ctrlWordMerge i_merge (
        .clk       (clk),
        .reset     (reset),
        .fetchBusy (fetchBusy),
        .fetchWord (fetchWord),
        .execWord  (execWord),
        .ctrl      (ctrl)
    );

endmodule

// ==== test/ctrlUnitModel.svh ====
`ifndef CTRL_UNIT_MODEL_SVH
`define CTRL_UNIT_MODEL_SVH

typedef ctrlPkg::ctrlWord_t wordList_t[$];

// alu step of the register and immediate forms
function automatic ctrlPkg::ctrlWord_t aluWord(ctrlPkg::aluOp_t op, logic imm);
    return '{writeAluOut: 1'b1, memAddrSel: ctrlPkg::MEM_PC, pcSrc: ctrlPkg::PC_ALUOUT,
             aluSrcA: ctrlPkg::SRCA_REG, aluSrcB: imm ? ctrlPkg::SRCB_IMM : ctrlPkg::SRCB_REG,
             aluOp: op, default: '0};
endfunction

function automatic ctrlPkg::ctrlWord_t saveWord(logic imm);
    return '{writeReg: 1'b1, memAddrSel: ctrlPkg::MEM_PC, pcSrc: ctrlPkg::PC_ALUOUT,
             aluSrcA: ctrlPkg::SRCA_REG, aluOp: ctrlPkg::ALU_ADD,
             regDst: imm ? ctrlPkg::DST_RT : ctrlPkg::DST_RD,
             regData: ctrlPkg::DATA_ALUOUT, default: '0};
endfunction

function automatic wordList_t expectedWords(ctrlPkg::instrFields_t in, ctrlPkg::aluFlags_t fl,
                                            int delay);
    wordList_t          q;
    ctrlPkg::ctrlWord_t w;
    logic               isDiv;
    logic               taken;
    isDiv = (in.funct == ctrlPkg::FUNCT_DIV);
    w = '{writeInstr: 1'b1, writeAluOut: 1'b1, memAddrSel: ctrlPkg::MEM_PC,
          aluSrcB: ctrlPkg::SRCB_FOUR, aluOp: ctrlPkg::ALU_ADD, default: '0};
    repeat (3)
        q.push_back(w);
    w = '{writePc: 1'b1, pcSrc: ctrlPkg::PC_ALUOUT, default: '0};
    q.push_back(w);
    w = '{writeAluOut: 1'b1, memAddrSel: ctrlPkg::MEM_PC, aluSrcB: ctrlPkg::SRCB_OFFSET,
          aluOp: ctrlPkg::ALU_ADD, pcSrc: ctrlPkg::PC_ALUOUT, default: '0};
    q.push_back(w);
    w.writeAluOut = 1'b0;   // decode loads the operands instead
    w.writeA = 1'b1;
    w.writeB = 1'b1;
    q.push_back(w);
    if (in.opcode == ctrlPkg::OP_RTYPE) begin
        case (in.funct)
            ctrlPkg::FUNCT_ADD, ctrlPkg::FUNCT_AND, ctrlPkg::FUNCT_SUB: begin
                q.push_back(aluWord(in.funct == ctrlPkg::FUNCT_ADD ? ctrlPkg::ALU_ADD :
                                    in.funct == ctrlPkg::FUNCT_AND ? ctrlPkg::ALU_AND :
                                    ctrlPkg::ALU_SUB, 1'b0));
                q.push_back(saveWord(1'b0));
            end
            ctrlPkg::FUNCT_MULT, ctrlPkg::FUNCT_DIV: begin
                w = '{multStart: !isDiv, divStart: isDiv, default: '0};
                q.push_back(w);
                repeat (delay + 1)
                    q.push_back(ctrlPkg::IDLE_WORD);
                w = '{writeHilo: 1'b1, hiloSel: isDiv, default: '0};
                q.push_back(w);
            end
            ctrlPkg::FUNCT_MFHI, ctrlPkg::FUNCT_MFLO: begin
                w = '{writeReg: 1'b1, regDst: ctrlPkg::DST_RD, default: '0};
                w.regData = (in.funct == ctrlPkg::FUNCT_MFHI) ? ctrlPkg::DATA_HI
                                                              : ctrlPkg::DATA_LO;
                q.push_back(w);
            end
            ctrlPkg::FUNCT_BREAK: begin
                w = '{writeAluOut: 1'b1, aluSrcB: ctrlPkg::SRCB_FOUR, aluOp: ctrlPkg::ALU_SUB,
                      default: '0};
                q.push_back(w);
                w = '{writePc: 1'b1, pcSrc: ctrlPkg::PC_ALUOUT, default: '0};
                q.push_back(w);
            end
            ctrlPkg::FUNCT_RTE: begin
                w = '{writePc: 1'b1, pcSrc: ctrlPkg::PC_EPC, default: '0};
                q.push_back(w);
            end
            default: ;  // unknown funct, back to fetch
        endcase
    end else begin
        case (in.opcode)
            ctrlPkg::OP_ADDI, ctrlPkg::OP_ADDIU: begin
                q.push_back(aluWord(ctrlPkg::ALU_ADD, 1'b1));
                q.push_back(saveWord(1'b1));
            end
            ctrlPkg::OP_BEQ, ctrlPkg::OP_BNE, ctrlPkg::OP_BLE, ctrlPkg::OP_BGT: begin
                case (in.opcode)
                    ctrlPkg::OP_BEQ: taken = fl.et;
                    ctrlPkg::OP_BNE: taken = !fl.et;
                    ctrlPkg::OP_BLE: taken = fl.et || fl.lt;
                    default:         taken = fl.gt;
                endcase
                w = '{aluSrcA: ctrlPkg::SRCA_REG, aluOp: ctrlPkg::ALU_CMP, default: '0};
                q.push_back(w);
                w = ctrlPkg::IDLE_WORD;
                if (taken) begin
                    w = '{writePc: 1'b1, writeAluOut: 1'b1, pcSrc: ctrlPkg::PC_ALUOUT,
                          default: '0};
                end
                q.push_back(w);
            end
            default: ;
        endcase
    end
    return q;
endfunction

`endif

// ==== test/ctrlUnitTb.sv ====
`timescale 1ns/1ps

module ctrlUnitTb;

    localparam int NUM_INSTR  = 200;
    localparam int MAX_CYCLES = NUM_INSTR * 20;

    typedef struct {
        ctrlPkg::ctrlWord_t word;
        int                 test;
        bit                 last;
        string              label;
    } expEntry_t;

    logic                  clk;
    logic                  reset;
    ctrlPkg::instrFields_t instr;
    ctrlPkg::aluFlags_t    flags;
    logic                  multEnd;
    logic                  divEnd;
    ctrlPkg::ctrlWord_t    ctrl;

    expEntry_t   expQ[$];
    logic [31:0] lfsr;
    int          cycles = 0;
    int          testErrs = 0;
    int          passed = 0;
    int          failed = 0;

    // ctrl fields from msb down
    string fieldNames[17] = '{"writePc", "writeA", "writeB", "writeAluOut", "writeInstr",
        "writeReg", "writeHilo", "hiloSel", "divStart", "multStart", "memAddrSel",
        "aluSrcA", "aluSrcB", "pcSrc", "regDst", "regData", "aluOp"};
    int fieldBits[17] = '{1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 3, 2, 3, 2, 2, 3, 3};

    localparam ctrlPkg::instrFields_t KNOWN[15] = '{
        {ctrlPkg::OP_RTYPE, ctrlPkg::FUNCT_ADD}, {ctrlPkg::OP_RTYPE, ctrlPkg::FUNCT_AND},
        {ctrlPkg::OP_RTYPE, ctrlPkg::FUNCT_SUB}, {ctrlPkg::OP_ADDI, 6'h00},
        {ctrlPkg::OP_ADDIU, 6'h00}, {ctrlPkg::OP_RTYPE, ctrlPkg::FUNCT_MULT},
        {ctrlPkg::OP_RTYPE, ctrlPkg::FUNCT_DIV}, {ctrlPkg::OP_RTYPE, ctrlPkg::FUNCT_MFHI},
        {ctrlPkg::OP_RTYPE, ctrlPkg::FUNCT_MFLO}, {ctrlPkg::OP_BEQ, 6'h00},
        {ctrlPkg::OP_BNE, 6'h00}, {ctrlPkg::OP_BLE, 6'h00}, {ctrlPkg::OP_BGT, 6'h00},
        {ctrlPkg::OP_RTYPE, ctrlPkg::FUNCT_BREAK}, {ctrlPkg::OP_RTYPE, ctrlPkg::FUNCT_RTE}};

    `include "ctrlUnitModel.svh"

    ctrlUnit i_dut (.*);

    // galois lfsr with taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] takeBits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return v;
    endfunction

    task automatic compareWord(ctrlPkg::ctrlWord_t expWord, ctrlPkg::ctrlWord_t actWord);
        int          pos;
        logic [31:0] e;
        logic [31:0] a;
        pos = $bits(ctrlPkg::ctrlWord_t);
        for (int f = 0; f < 17; f++) begin
            pos = pos - fieldBits[f];
            e = (32'(expWord) >> pos) & ((32'd1 << fieldBits[f]) - 1);
            a = (32'(actWord) >> pos) & ((32'd1 << fieldBits[f]) - 1);
            if (e !== a) begin
                $display("FAILED ctrl.%s: expected %0h, got %0h (cycle %0d)",
                         fieldNames[f], e, a, cycles);
                testErrs++;
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("timeout: run still going after %0d cycles", MAX_CYCLES);
            $display("=== FAIL ===");
            $finish;
        end
    end

    // ctrl is stable at the falling edge
    always @(negedge clk) begin
        expEntry_t ent;
        if (cycles > 0 && expQ.size() > 0) begin
            ent = expQ.pop_front();
            compareWord(ent.word, ctrl);
            if (ent.last) begin
                $display("test %0d, %s: %0d mismatches", ent.test, ent.label, testErrs);
                if (testErrs == 0) begin
                    passed++;
                end else begin
                    failed++;
                end
                testErrs = 0;
            end
        end
    end

    initial begin
        ctrlPkg::instrFields_t in;
        ctrlPkg::aluFlags_t    fl;
        wordList_t             words;
        string                 label;
        int                    sel;
        int                    delay;
        logic                  isMult;
        logic                  isDiv;
        reset = 1'b1;
        instr = '0;
        flags = '0;
        multEnd = 1'b0;
        divEnd = 1'b0;
        lfsr = 32'd87247;
        expQ.push_back('{ctrlPkg::RESET_WORD, 0, 1'b0, "reset"});
        expQ.push_back('{ctrlPkg::RESET_WORD, 0, 1'b1, "reset"});
        repeat (2) @(posedge clk);
        #1 reset = 1'b0;
        @(posedge clk);
        #1;
        for (int t = 1; t <= NUM_INSTR; t++) begin
            sel = takeBits(4);
            if (sel < 15) begin
                in = KNOWN[sel];
            end else begin
                // mostly unknown codes with register type half the time
                in.opcode = takeBits(1) ? ctrlPkg::OP_RTYPE : ctrlPkg::opcode_t'(takeBits(6));
                in.funct = ctrlPkg::funct_t'(takeBits(6));
            end
            if (in.opcode != ctrlPkg::OP_RTYPE) begin
                in.funct = ctrlPkg::funct_t'(takeBits(6));   // ignored outside register type
            end
            fl = ctrlPkg::aluFlags_t'(takeBits(3));
            delay = takeBits(3);
            isMult = (in.opcode == ctrlPkg::OP_RTYPE) && (in.funct == ctrlPkg::FUNCT_MULT);
            isDiv = (in.opcode == ctrlPkg::OP_RTYPE) && (in.funct == ctrlPkg::FUNCT_DIV);
            label = $sformatf("opcode %h funct %h flags %h delay %0d",
                              in.opcode, in.funct, fl, delay);
            words = expectedWords(in, fl, delay);
            foreach (words[k])
                expQ.push_back('{words[k], t, k == words.size() - 1, label});
            instr = in;
            for (int k = 0; k < words.size(); k++) begin
                multEnd = isMult ? (k == 6 + delay) : 1'(takeBits(1));
                divEnd = isDiv ? (k == 6 + delay) : 1'(takeBits(1));
                flags = (k == 6) ? fl : ctrlPkg::aluFlags_t'(takeBits(3));  // noise elsewhere
                @(posedge clk);
                #1;
            end
        end
        $display("%0d tests: %0d passed, %0d failed", passed + failed, passed, failed);
        if (failed == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+test
logic/ctrlPkg.sv
logic/fetchDecodeSeq.sv
logic/executeSeq.sv
logic/ctrlWordMerge.sv
logic/ctrlUnit.sv
test/ctrlUnitTb.sv

// ==== Bender.yml ====
package:
  name: ctrl_unit

sources:
  - logic/ctrlPkg.sv
  - logic/fetchDecodeSeq.sv
  - logic/executeSeq.sv
  - logic/ctrlWordMerge.sv
  - logic/ctrlUnit.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/ctrlUnitTb.sv
